// ==== project.f ====
+incdir+tb
common/loader_pkg.sv
loader/crt_chip_parser.sv
loader/image_decoder.sv
loader/basic_ptr_injector.sv
src/io_slot_writer.sv
src/c64_loader_top.sv
tb/tb_c64_loader.sv

// ==== tb/loader_tests.svh ====
/* Directed loader tests, included inside the testbench module.
   The PRG test leaves the download open; the injection test closes it. */
`ifndef LOADER_TESTS_SVH
`define LOADER_TESTS_SVH

// Header 0x0801 then n payload bytes
task automatic test_prg_load(input int n);
	logic [7:0] b;
	begin
		clear_logs();
		start_download(LOAD_PRG);
		send_byte(0, 8'h01);
		send_byte(1, 8'h08);
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			send_byte(i + 2, b);
			expect_write(32'h0801 + i, b);
		end
		wait_ready("PRG drain");
		compare_log("prg_load");
		prg_end_exp = 16'h0801 + 16'(n);
	end
endtask

task automatic test_basic_inject();
	int n;
	begin
		clear_logs();
		// Zero-page pointers in walk order
		expect_write(32'h2B, 8'h01);
		expect_write(32'h2C, 8'h08);
		expect_write(32'h2D, prg_end_exp[7:0]);
		expect_write(32'h2E, prg_end_exp[15:8]);
		expect_write(32'h2F, prg_end_exp[7:0]);
		expect_write(32'h30, prg_end_exp[15:8]);
		expect_write(32'h31, prg_end_exp[7:0]);
		expect_write(32'h32, prg_end_exp[15:8]);
		expect_write(32'hAC, 8'h00);
		expect_write(32'hAD, 8'h00);
		expect_write(32'hAE, prg_end_exp[7:0]);
		expect_write(32'hAF, prg_end_exp[15:8]);
		ioctl_download_i = 1'b0;
		n = 0;
		while (done_count == 0 && n < INJECT_LIMIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (done_count == 0) begin
			$display("timeout: inject_done_o never pulsed after the PRG download");
			timeout_count++;
		end
		wait_ready("injection drain");
		// Room for a stray second done pulse
		repeat (16) @(posedge clk_sys);
		#1;
		compare_log("basic_inject");
		if (done_count != 1)
			report_mismatch("basic_inject done pulses", 1, done_count);
	end
endtask

task automatic send_crt_header(input logic [15:0] id, input logic [7:0] exrom,
	input logic [7:0] game);
	logic [7:0] b;
	begin
		for (int i = 0; i < CRT_CHIP_START; i++) begin
			case (i)
				CRT_HDR_ID_HI: b = id[15:8];
				CRT_HDR_ID_LO: b = id[7:0];
				CRT_HDR_EXROM: b = exrom;
				CRT_HDR_GAME:  b = game;
				default:       b = 8'(i);
			endcase
			send_byte(i, b);
		end
	end
endtask

task automatic wait_attached(input logic level);
	int n;
	begin
		n = 0;
		while (cart_attached_o !== level && n < WAIT_LIMIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
	end
endtask

task automatic test_crt_header();
	begin
		clear_logs();
		start_download(LOAD_CRT);
		send_crt_header(16'h0013, 8'h00, 8'h01);
		end_download();
		if (cart_id_o !== 16'h0013)
			report_mismatch("crt_header id", 16'h0013, cart_id_o);
		if (cart_exrom_o !== 8'h00)
			report_mismatch("crt_header exrom", 8'h00, cart_exrom_o);
		if (cart_game_o !== 8'h01)
			report_mismatch("crt_header game", 8'h01, cart_game_o);
		if (log_addr.size() != 0)
			report_mismatch("crt_header write count", 0, log_addr.size());
		wait_attached(1'b1);
		if (cart_attached_o !== 1'b1)
			report_mismatch("crt_header attached", 1'b1, cart_attached_o);
		cart_detach_i = 1'b1;
		@(posedge clk_sys);
		#1;
		cart_detach_i = 1'b0;
		wait_attached(1'b0);
		if (cart_attached_o !== 1'b0)
			report_mismatch("crt_header detached", 1'b0, cart_attached_o);
	end
endtask

// One CHIP block of len data bytes whose data belongs at base
task automatic send_chip(inout int off, input logic [7:0] kind, input logic [15:0] bank,
	input logic [15:0] laddr, input int len, input logic [31:0] base);
	logic [7:0]  hdr [16];
	logic [31:0] total;
	logic [7:0]  b;
	begin
		total = 32'(len) + 32'(CHIP_HDR_BYTES);
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, total[31:24], total[23:16], total[15:8],
			total[7:0], 8'h00, kind, bank[15:8], bank[7:0], laddr[15:8], laddr[7:0],
			8'(len >> 8), 8'(len)};
		for (int i = 0; i < 16; i++) begin
			send_byte(off, hdr[i]);
			off++;
		end
		exp_bank.push_back({base, kind, bank, laddr, 16'(len)});
		for (int i = 0; i < len; i++) begin
			rand_byte(b);
			send_byte(off, b);
			off++;
			expect_write(base + i, b);
		end
	end
endtask

task automatic test_crt_chips();
	int          off;
	logic [31:0] base2;
	begin
		clear_logs();
		start_download(LOAD_CRT);
		send_crt_header(16'h0005, 8'h00, 8'h00);
		off = CRT_CHIP_START;
		send_chip(off, 8'h00, 16'h0000, 16'h8000, 10, CRT_BASE);
		// Second bank starts on the next 8 KB boundary
		base2 = ((CRT_BASE + 10 + (1 << CRT_BANK_ALIGN_BITS) - 1) >> CRT_BANK_ALIGN_BITS)
			<< CRT_BANK_ALIGN_BITS;
		send_chip(off, 8'h02, 16'h0001, 16'hA000, 6, base2);
		end_download();
		compare_log("crt_chips");
		if (bank_log.size() != 2)
			report_mismatch("crt_chips bank strobes", 2, bank_log.size());
		for (int i = 0; i < 2 && i < bank_log.size(); i++) begin
			if (bank_log[i] !== exp_bank[i])
				report_mismatch("crt_chips bank fields", exp_bank[i], bank_log[i]);
		end
	end
endtask

task automatic test_tap_load(input int n);
	logic [7:0] b;
	begin
		clear_logs();
		start_download(LOAD_TAP);
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			send_byte(i, b);
			expect_write(TAP_ADDR + i, b);
		end
		end_download();
		compare_log("tap_load");
	end
endtask

// Each stored byte must raise ioctl_wait_o before the next may go
task automatic test_back_pressure(input int n);
	logic [7:0] b;
	begin
		clear_logs();
		start_download(LOAD_TAP);
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			stream_byte(i, b);
			expect_write(TAP_ADDR + i, b);
			if (ioctl_wait_o !== 1'b1)
				report_mismatch("back_pressure wait", 1'b1, ioctl_wait_o);
		end
		end_download();
		compare_log("back_pressure");
	end
endtask

`endif

// ==== tb/tb_c64_loader.sv ====
/* Directed testbench for the download loader with a free-running I/O phase.
   Memory is not modeled; every write strobe is logged and compared in order. */
module tb_c64_loader;

	timeunit 1ns;
	timeprecision 100ps;

	import loader_pkg::*;

	localparam int WAIT_LIMIT   = 100;
	localparam int INJECT_LIMIT = 3000;

	logic                  clk_sys;
	logic                  RESET;
	logic                  ioctl_download_i;
	logic [7:0]            ioctl_index_i;
	logic                  ioctl_wr_i;
	logic [MEM_ADDR_W-1:0] ioctl_addr_i;
	logic [7:0]            ioctl_data_i;
	logic                  io_cycle_i;
	logic                  cart_detach_i;
	logic                  ioctl_wait_o;
	logic [MEM_ADDR_W-1:0] mem_addr_o;
	logic [7:0]            mem_data_o;
	logic                  mem_ce_o;
	logic                  mem_we_o;
	logic [15:0]           cart_id_o;
	logic [7:0]            cart_exrom_o;
	logic [7:0]            cart_game_o;
	logic                  cart_attached_o;
	logic [7:0]            cart_bank_type_o;
	logic [15:0]           cart_bank_num_o;
	logic [15:0]           cart_bank_laddr_o;
	logic [15:0]           cart_bank_size_o;
	logic [MEM_ADDR_W-1:0] cart_bank_addr_o;
	logic                  cart_bank_wr_o;
	logic                  inject_done_o;

	// Observed and expected memory writes, and bank strobes as {addr, type, num, laddr, size}
	logic [31:0] log_addr[$];
	logic [7:0]  log_data[$];
	logic [87:0] bank_log[$];
	logic [31:0] exp_addr[$];
	logic [7:0]  exp_data[$];
	logic [87:0] exp_bank[$];

	logic        we_q;
	int          done_count;
	int          mismatch_count;
	int          timeout_count;
	logic [15:0] lfsr;
	logic [15:0] prg_end_exp;

	c64_loader_top i_c64_loader_top (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.ioctl_download_i  (ioctl_download_i),
		.ioctl_index_i     (ioctl_index_i),
		.ioctl_wr_i        (ioctl_wr_i),
		.ioctl_addr_i      (ioctl_addr_i),
		.ioctl_data_i      (ioctl_data_i),
		.io_cycle_i        (io_cycle_i),
		.cart_detach_i     (cart_detach_i),
		.ioctl_wait_o      (ioctl_wait_o),
		.mem_addr_o        (mem_addr_o),
		.mem_data_o        (mem_data_o),
		.mem_ce_o          (mem_ce_o),
		.mem_we_o          (mem_we_o),
		.cart_id_o         (cart_id_o),
		.cart_exrom_o      (cart_exrom_o),
		.cart_game_o       (cart_game_o),
		.cart_attached_o   (cart_attached_o),
		.cart_bank_type_o  (cart_bank_type_o),
		.cart_bank_num_o   (cart_bank_num_o),
		.cart_bank_laddr_o (cart_bank_laddr_o),
		.cart_bank_size_o  (cart_bank_size_o),
		.cart_bank_addr_o  (cart_bank_addr_o),
		.cart_bank_wr_o    (cart_bank_wr_o),
		.inject_done_o     (inject_done_o)
	);

	// ============================================================
	// Clock, I/O phase and monitor
	// ============================================================
	always #5 clk_sys = ~clk_sys;

	// CPU I/O phase, 4 cycles high then 4 cycles low
	always begin
		repeat (4) @(posedge clk_sys);
		#1;
		io_cycle_i = ~io_cycle_i;
	end

	always @(posedge clk_sys) begin
		if (RESET) begin
			we_q <= 1'b0;
		end else begin
			we_q <= mem_we_o;
			// Chip enable and write enable rise and fall together
			if (mem_ce_o !== mem_we_o)
				report_mismatch("mem strobes ce", mem_we_o, mem_ce_o);
			if (mem_we_o && !we_q) begin
				log_addr.push_back(32'(mem_addr_o));
				log_data.push_back(mem_data_o);
			end
			if (inject_done_o)
				done_count++;
			if (cart_bank_wr_o)
				bank_log.push_back({32'(cart_bank_addr_o), cart_bank_type_o, cart_bank_num_o,
					cart_bank_laddr_o, cart_bank_size_o});
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	// 16-bit Galois LFSR, shifting right
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		begin
			n = s >> 1;
			if (s[0])
				n = n ^ 16'hB400;
			return n;
		end
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		begin
			b = 8'h00;
			for (int i = 0; i < 8; i++) begin
				lfsr = lfsr_step(lfsr);
				b = {b[6:0], lfsr[0]};
			end
		end
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		begin
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic wait_ready(input string what);
		int n;
		begin
			n = 0;
			while (ioctl_wait_o && n < WAIT_LIMIT) begin
				@(posedge clk_sys);
				#1;
				n++;
			end
			if (ioctl_wait_o) begin
				$display("timeout: ioctl_wait_o stayed high during %s", what);
				timeout_count++;
			end
		end
	endtask

	// One byte per wr pulse, then one idle cycle
	task automatic send_byte(input logic [31:0] addr, input logic [7:0] data);
		begin
			wait_ready("byte send");
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = addr[MEM_ADDR_W-1:0];
			ioctl_data_i = data;
			@(posedge clk_sys);
			#1;
			ioctl_wr_i = 1'b0;
			@(posedge clk_sys);
			#1;
		end
	endtask

	// One byte per wr pulse with no idle cycle, so the next may follow at once
	task automatic stream_byte(input logic [31:0] addr, input logic [7:0] data);
		begin
			wait_ready("byte stream");
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = addr[MEM_ADDR_W-1:0];
			ioctl_data_i = data;
			@(posedge clk_sys);
			#1;
			ioctl_wr_i = 1'b0;
		end
	endtask

	task automatic start_download(input logic [7:0] index);
		begin
			ioctl_index_i    = index;
			ioctl_download_i = 1'b1;
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic end_download();
		begin
			wait_ready("download end");
			ioctl_download_i = 1'b0;
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic expect_write(input logic [31:0] addr, input logic [7:0] data);
		begin
			exp_addr.push_back(addr);
			exp_data.push_back(data);
		end
	endtask

	task automatic clear_logs();
		begin
			log_addr.delete();
			log_data.delete();
			bank_log.delete();
			exp_addr.delete();
			exp_data.delete();
			exp_bank.delete();
			done_count = 0;
		end
	endtask

	task automatic compare_log(input string name);
		begin
			if (log_addr.size() != exp_addr.size())
				report_mismatch({name, " write count"}, exp_addr.size(), log_addr.size());
			for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
				if (log_addr[i] !== exp_addr[i])
					report_mismatch({name, " address"}, exp_addr[i], log_addr[i]);
				if (log_data[i] !== exp_data[i])
					report_mismatch({name, " data"}, exp_data[i], log_data[i]);
			end
		end
	endtask

	`include "loader_tests.svh"

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		clk_sys          = 1'b0;
		RESET            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'h00;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = 8'h00;
		io_cycle_i       = 1'b0;
		cart_detach_i    = 1'b0;
		lfsr             = 16'd30;
		done_count       = 0;
		mismatch_count   = 0;
		timeout_count    = 0;
		prg_end_exp      = 16'h0000;
		repeat (8) @(posedge clk_sys);
		#1;
		RESET = 1'b0;

		if ({mem_ce_o, mem_we_o, ioctl_wait_o, cart_bank_wr_o, inject_done_o,
			cart_attached_o} !== 6'b0)
			report_mismatch("reset outputs", 6'b0, {mem_ce_o, mem_we_o, ioctl_wait_o,
				cart_bank_wr_o, inject_done_o, cart_attached_o});

		test_prg_load(20);
		test_basic_inject();
		test_crt_header();
		test_crt_chips();
		test_tap_load(16);
		test_back_pressure(48);

		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== src/c64_loader_top.sv ====
/* Download loader: ioctl stream in, byte writes into system memory out.
   The host must hold off ioctl_wr_i while ioctl_wait_o is high. */
module c64_loader_top (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              ioctl_download_i,
	input  logic [7:0]                        ioctl_index_i,
	input  logic                              ioctl_wr_i,
	input  logic [loader_pkg::MEM_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]                        ioctl_data_i,
	input  logic                              io_cycle_i,
	input  logic                              cart_detach_i,
	output logic                              ioctl_wait_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] mem_addr_o,
	output logic [7:0]                        mem_data_o,
	output logic                              mem_ce_o,
	output logic                              mem_we_o,
	output logic [15:0]                       cart_id_o,
	output logic [7:0]                        cart_exrom_o,
	output logic [7:0]                        cart_game_o,
	output logic                              cart_attached_o,
	output logic [7:0]                        cart_bank_type_o,
	output logic [15:0]                       cart_bank_num_o,
	output logic [15:0]                       cart_bank_laddr_o,
	output logic [15:0]                       cart_bank_size_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] cart_bank_addr_o,
	output logic                              cart_bank_wr_o,
	output logic                              inject_done_o
);

	import loader_pkg::*;

	logic                  dec_req;
	logic [MEM_ADDR_W-1:0] dec_addr;
	logic [7:0]            dec_data;
	logic [15:0]           prg_end;
	logic                  prg_done;
	logic                  inj_req;
	logic [MEM_ADDR_W-1:0] inj_addr;
	logic [7:0]            inj_data;
	logic                  inj_busy;
	logic                  slot_busy;

	// ============================================================
	// Decode stage
	// ============================================================
	image_decoder #(.ADDR_W(MEM_ADDR_W)) i_image_decoder (
		.clk_sys (clk_sys), .RESET (RESET),
		.ioctl_download_i (ioctl_download_i), .ioctl_index_i (ioctl_index_i),
		.ioctl_wr_i (ioctl_wr_i), .ioctl_addr_i (ioctl_addr_i),
		.ioctl_data_i (ioctl_data_i), .cart_detach_i (cart_detach_i),
		.dec_req_o (dec_req), .dec_addr_o (dec_addr), .dec_data_o (dec_data),
		.prg_end_o (prg_end), .prg_done_o (prg_done),
		.cart_id_o (cart_id_o), .cart_exrom_o (cart_exrom_o),
		.cart_game_o (cart_game_o), .cart_attached_o (cart_attached_o),
		.cart_bank_type_o (cart_bank_type_o), .cart_bank_num_o (cart_bank_num_o),
		.cart_bank_laddr_o (cart_bank_laddr_o), .cart_bank_size_o (cart_bank_size_o),
		.cart_bank_addr_o (cart_bank_addr_o), .cart_bank_wr_o (cart_bank_wr_o)
	);

	// Zero-page pointer fixup after a PRG
	basic_ptr_injector #(.ADDR_W(MEM_ADDR_W)) i_basic_ptr_injector (
		.clk_sys (clk_sys), .RESET (RESET),
		.start_i (prg_done), .prg_end_i (prg_end), .slot_busy_i (slot_busy),
		.inj_req_o (inj_req), .inj_addr_o (inj_addr), .inj_data_o (inj_data),
		.inj_busy_o (inj_busy), .inject_done_o (inject_done_o)
	);

	// ============================================================
	// Memory side
	// ============================================================
	io_slot_writer #(.ADDR_W(MEM_ADDR_W)) i_io_slot_writer (
		.clk_sys (clk_sys), .RESET (RESET),
		.dec_req_i (dec_req), .dec_addr_i (dec_addr), .dec_data_i (dec_data),
		.inj_req_i (inj_req), .inj_addr_i (inj_addr), .inj_data_i (inj_data),
		.inj_busy_i (inj_busy), .io_cycle_i (io_cycle_i),
		.slot_busy_o (slot_busy), .ioctl_wait_o (ioctl_wait_o),
		.mem_addr_o (mem_addr_o), .mem_data_o (mem_data_o),
		.mem_ce_o (mem_ce_o), .mem_we_o (mem_we_o)
	);

endmodule

// ==== src/io_slot_writer.sv ====
/* Single-entry write buffer that drains into the CPU's free I/O cycle.
   Requests must not arrive while a write is still pending. */
module io_slot_writer #(
	parameter int ADDR_W = loader_pkg::MEM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dec_req_i,
	input  logic [ADDR_W-1:0] dec_addr_i,
	input  logic [7:0]        dec_data_i,
	input  logic              inj_req_i,
	input  logic [ADDR_W-1:0] inj_addr_i,
	input  logic [7:0]        inj_data_i,
	input  logic              inj_busy_i,
	input  logic              io_cycle_i,
	output logic              slot_busy_o,
	output logic              ioctl_wait_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [7:0]        mem_data_o,
	output logic              mem_ce_o,
	output logic              mem_we_o
);

	logic              pend_q;
	logic [ADDR_W-1:0] pend_addr;
	logic [7:0]        pend_data;
	logic              io_cycle_q;
	logic              mem_act_q;
	logic              io_fall;
	logic              io_settled;
	logic              issue;

	assign io_fall    = io_cycle_q & ~io_cycle_i;
	// I/O phase seen high on two samples in a row
	assign io_settled = io_cycle_q & io_cycle_i;
	assign issue      = pend_q & ~mem_act_q & io_fall;

	assign slot_busy_o  = pend_q;
	// Also high in the request cycle so the host cannot slip in a second byte
	assign ioctl_wait_o = pend_q | dec_req_i | inj_busy_i;
	assign mem_ce_o     = mem_act_q;
	assign mem_we_o     = mem_act_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pend_q     <= 1'b0;
			io_cycle_q <= 1'b0;
			mem_act_q  <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			if (issue)
				mem_act_q <= 1'b1;
			if (mem_act_q && io_settled) begin
				mem_act_q <= 1'b0;
				pend_q    <= 1'b0;
			end
			if (dec_req_i | inj_req_i)
				pend_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dec_req_i) begin
			pend_addr <= dec_addr_i;
			pend_data <= dec_data_i;
		end else if (inj_req_i) begin
			pend_addr <= inj_addr_i;
			pend_data <= inj_data_i;
		end
		if (issue) begin
			mem_addr_o <= pend_addr;
			mem_data_o <= pend_data;
		end
	end

endmodule

// ==== loader/basic_ptr_injector.sv ====
/* Rewrites the BASIC zero-page pointers the way a LOAD command leaves them.
   Start only after the last program byte has been requested. */
module basic_ptr_injector #(
	parameter int ADDR_W = loader_pkg::MEM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              start_i,
	input  logic [15:0]       prg_end_i,
	input  logic              slot_busy_i,
	output logic              inj_req_o,
	output logic [ADDR_W-1:0] inj_addr_o,
	output logic [7:0]        inj_data_o,
	output logic              inj_busy_o,
	output logic              inject_done_o
);

	import loader_pkg::*;

	inj_state_e state_q;
	// One bit wider than zero page so the end address fits
	logic [8:0] walk_addr;
	logic       ptr_hit;
	logic [7:0] ptr_byte;

	assign inj_req_o  = (state_q == ISSUE) && !slot_busy_i;
	assign inj_addr_o = ADDR_W'(walk_addr[7:0]);
	assign inj_data_o = ptr_byte;
	assign inj_busy_o = (state_q != IDLE);

	always_comb begin
		ptr_hit  = 1'b1;
		ptr_byte = 8'h00;
		case (walk_addr)
			// Start of BASIC text stays at its reset value
			9'h02B: ptr_byte = 8'h01;
			9'h02C: ptr_byte = 8'h08;
			9'h0AC, 9'h0AD: ptr_byte = 8'h00;
			// VAR, ARY, STR and load end all point past the program
			9'h02D, 9'h02F, 9'h031, 9'h0AE: ptr_byte = prg_end_i[7:0];
			9'h02E, 9'h030, 9'h032, 9'h0AF: ptr_byte = prg_end_i[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q       <= IDLE;
			walk_addr     <= 9'd0;
			inject_done_o <= 1'b0;
		end else begin
			inject_done_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q   <= WALK;
						walk_addr <= 9'd0;
					end
				end
				WALK: begin
					if (walk_addr == 9'(INJ_END_ADDR)) begin
						state_q       <= IDLE;
						inject_done_o <= 1'b1;
					end else if (ptr_hit) begin
						state_q <= ISSUE;
					end else begin
						walk_addr <= walk_addr + 9'd1;
					end
				end
				ISSUE: begin
					// Hold until the slot writer can take the byte
					if (!slot_busy_i) begin
						state_q   <= WALK;
						walk_addr <= walk_addr + 9'd1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

endmodule

// ==== loader/image_decoder.sv ====
/* Turns the ioctl byte stream into memory write requests per load kind.
   PRG load address is 16 bits; CRT banks need a valid CHIP header before data. */
module image_decoder #(
	parameter int ADDR_W = loader_pkg::MEM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download_i,
	input  logic [7:0]        ioctl_index_i,
	input  logic              ioctl_wr_i,
	input  logic [ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]        ioctl_data_i,
	input  logic              cart_detach_i,
	output logic              dec_req_o,
	output logic [ADDR_W-1:0] dec_addr_o,
	output logic [7:0]        dec_data_o,
	output logic [15:0]       prg_end_o,
	output logic              prg_done_o,
	output logic [15:0]       cart_id_o,
	output logic [7:0]        cart_exrom_o,
	output logic [7:0]        cart_game_o,
	output logic              cart_attached_o,
	output logic [7:0]        cart_bank_type_o,
	output logic [15:0]       cart_bank_num_o,
	output logic [15:0]       cart_bank_laddr_o,
	output logic [15:0]       cart_bank_size_o,
	output logic [ADDR_W-1:0] cart_bank_addr_o,
	output logic              cart_bank_wr_o
);

	import loader_pkg::*;

	load_kind_e        kind;
	logic              download_q;
	logic              detach_q;
	logic              byte_wr;
	logic              store_byte;
	logic              chip_byte;
	logic              chip_restart;
	logic              chip_align;
	logic              chip_data;
	logic [ADDR_W-1:0] load_addr;
	logic [ADDR_W-1:0] wr_addr;

	assign kind    = load_kind_e'(ioctl_index_i);
	assign byte_wr = ioctl_wr_i & ioctl_download_i;

	// CHIP blocks follow the file header
	assign chip_byte    = byte_wr && (kind == LOAD_CRT) && (ioctl_addr_i >= CRT_CHIP_START);
	assign chip_restart = byte_wr && (kind == LOAD_CRT) && (ioctl_addr_i == '0);

	// First tape byte goes straight to the tape base
	assign wr_addr = (kind == LOAD_TAP && ioctl_addr_i == '0) ? ADDR_W'(TAP_ADDR) : load_addr;

	assign prg_done_o       = download_q & ~ioctl_download_i & (kind == LOAD_PRG);
	assign cart_bank_addr_o = load_addr;

	always_comb begin
		store_byte = 1'b0;
		if (byte_wr) begin
			case (kind)
				LOAD_PRG: store_byte = (ioctl_addr_i > ADDR_W'(1));
				LOAD_CRT: store_byte = chip_data;
				LOAD_TAP: store_byte = 1'b1;
				default:  store_byte = 1'b0;
			endcase
		end
	end

	crt_chip_parser i_crt_chip_parser (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.chip_byte_i    (chip_byte),
		.chip_data_i    (ioctl_data_i),
		.chip_restart_i (chip_restart),
		.align_o        (chip_align),
		.data_byte_o    (chip_data),
		.bank_type_o    (cart_bank_type_o),
		.bank_num_o     (cart_bank_num_o),
		.bank_laddr_o   (cart_bank_laddr_o),
		.bank_size_o    (cart_bank_size_o),
		.bank_wr_o      (cart_bank_wr_o)
	);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_q      <= 1'b0;
			detach_q        <= 1'b0;
			dec_req_o       <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_q <= ioctl_download_i;
			detach_q   <= cart_detach_i;
			dec_req_o  <= store_byte;
			// Attach once the whole image is in memory
			if (kind == LOAD_CRT && download_q != ioctl_download_i)
				cart_attached_o <= download_q;
			if (cart_detach_i & ~detach_q)
				cart_attached_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			dec_addr_o <= wr_addr;
			dec_data_o <= ioctl_data_i;
			if (store_byte)
				load_addr <= wr_addr + 1'b1;
			case (kind)
				LOAD_PRG: begin
					if (ioctl_addr_i == '0) begin
						load_addr <= ADDR_W'(ioctl_data_i);
						prg_end_o <= {8'h00, ioctl_data_i};
					end else if (ioctl_addr_i == ADDR_W'(1)) begin
						load_addr[15:8] <= ioctl_data_i;
						prg_end_o[15:8] <= ioctl_data_i;
					end else begin
						prg_end_o <= prg_end_o + 16'd1;
					end
				end
				LOAD_CRT: begin
					if (ioctl_addr_i == '0)
						load_addr <= ADDR_W'(CRT_BASE);
					if (ioctl_addr_i == CRT_HDR_ID_HI)
						cart_id_o[15:8] <= ioctl_data_i;
					if (ioctl_addr_i == CRT_HDR_ID_LO)
						cart_id_o[7:0] <= ioctl_data_i;
					if (ioctl_addr_i == CRT_HDR_EXROM)
						cart_exrom_o <= ioctl_data_i;
					if (ioctl_addr_i == CRT_HDR_GAME)
						cart_game_o <= ioctl_data_i;
					// Round up to the next bank boundary
					if (chip_align && load_addr[CRT_BANK_ALIGN_BITS-1:0] != '0)
						load_addr <= {load_addr[ADDR_W-1:CRT_BANK_ALIGN_BITS] + 1'b1,
							{CRT_BANK_ALIGN_BITS{1'b0}}};
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== loader/crt_chip_parser.sv ====
/* Walks CRT CHIP blocks: 16-byte header, then length minus 16 data bytes.
   A block length below the header size is not handled. */
module crt_chip_parser (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        chip_byte_i,
	input  logic [7:0]  chip_data_i,
	input  logic        chip_restart_i,
	output logic        align_o,
	output logic        data_byte_o,
	output logic [7:0]  bank_type_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic        bank_wr_o
);

	import loader_pkg::*;

	// Index of the next header byte, zero outside a header
	logic [3:0]  hdr_cnt;
	// Data bytes still to come in the current block
	logic [31:0] blk_len;
	logic        hdr_last_q;
	logic        in_header;

	assign in_header = (hdr_cnt != 4'd0);

	// A byte with no header and no data left opens a new CHIP header
	assign align_o     = chip_byte_i && !in_header && (blk_len == 32'd0);
	assign data_byte_o = chip_byte_i && !in_header && (blk_len != 32'd0);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_cnt    <= 4'd0;
			blk_len    <= 32'd0;
			hdr_last_q <= 1'b0;
			bank_wr_o  <= 1'b0;
		end else begin
			// Bank fields settle one cycle before the strobe
			hdr_last_q <= chip_byte_i && (hdr_cnt == 4'd15);
			bank_wr_o  <= hdr_last_q;
			if (chip_restart_i) begin
				hdr_cnt <= 4'd0;
				blk_len <= 32'd0;
			end else if (chip_byte_i) begin
				if (align_o) begin
					hdr_cnt <= 4'd1;
				end else if (in_header) begin
					// Wraps to zero after byte 15
					hdr_cnt <= hdr_cnt + 4'd1;
					case (hdr_cnt)
						4'd4, 4'd5, 4'd6, 4'd7: blk_len <= {blk_len[23:0], chip_data_i};
						4'd8:    blk_len <= blk_len - 32'(CHIP_HDR_BYTES);
						default: ;
					endcase
				end else begin
					blk_len <= blk_len - 32'd1;
				end
			end
		end
	end

	// Header fields are big-endian
	always_ff @(posedge clk_sys) begin
		if (chip_byte_i && in_header) begin
			case (hdr_cnt)
				4'd9:  bank_type_o        <= chip_data_i;
				4'd10: bank_num_o[15:8]   <= chip_data_i;
				4'd11: bank_num_o[7:0]    <= chip_data_i;
				4'd12: bank_laddr_o[15:8] <= chip_data_i;
				4'd13: bank_laddr_o[7:0]  <= chip_data_i;
				4'd14: bank_size_o[15:8]  <= chip_data_i;
				4'd15: bank_size_o[7:0]   <= chip_data_i;
				default: ;
			endcase
		end
	end

endmodule

// ==== common/loader_pkg.sv ====
/* Load kinds, memory map and CRT layout constants shared by the loader blocks.
   Index codes follow the host's menu numbering; all other indices are ignored. */
package loader_pkg;

	// ============================================================
	// Memory map
	// ============================================================

	// Width of a system memory byte address
	localparam int MEM_ADDR_W = 25;

	// Tape images are stored from here upward
	localparam int unsigned TAP_ADDR = 32'h0020_0000;

	// Cartridge bank data starts here
	localparam int unsigned CRT_BASE = 32'h0010_0000;

	// ============================================================
	// CRT file layout
	// ============================================================

	// File header fields, big-endian id
	localparam int unsigned CRT_HDR_ID_HI = 32'h16;
	localparam int unsigned CRT_HDR_ID_LO = 32'h17;
	localparam int unsigned CRT_HDR_EXROM = 32'h18;
	localparam int unsigned CRT_HDR_GAME  = 32'h19;

	// First CHIP block follows the 64-byte file header
	localparam int unsigned CRT_CHIP_START = 32'h40;

	// Banks land on 8 KB boundaries
	localparam int CRT_BANK_ALIGN_BITS = 13;

	// CHIP header length, included in the block length field
	localparam int unsigned CHIP_HDR_BYTES = 16;

	// ============================================================
	// BASIC pointer injection
	// ============================================================

	// Zero-page walk stops here
	localparam int unsigned INJ_END_ADDR = 32'h100;

	typedef enum logic [7:0] {
		LOAD_PRG = 8'd4,
		LOAD_CRT = 8'd5,
		LOAD_TAP = 8'd6
	} load_kind_e;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		ISSUE
	} inj_state_e;

endpackage
